// ==== isaPkg.sv ====
// Instruction set definitions
`default_nettype none

package isaPkg;

  // Instruction word size
  localparam int instrWidth = 16;

  // Register file depth
  localparam int numRegs = 8;

  // Opcode field
  localparam int opcodeHi = 15;
  localparam int opcodeLo = 12;
  localparam int opcodeWidth = opcodeHi - opcodeLo + 1;

  // Destination and second source register
  localparam int rdHi = 11;
  localparam int rdLo = 9;

  // First source register
  localparam int rsHi = 8;
  localparam int rsLo = 6;

  // Shift amount for SHL and SHR
  localparam int shamtHi = 3;
  localparam int shamtLo = 0;

  // LDI immediate, sign-extended on decode
  localparam int immHi = 8;
  localparam int immLo = 0;

  typedef logic [instrWidth-1:0] instrWordT;
  typedef logic [$clog2(numRegs)-1:0] regIdxT;

  // Codes above opLdi are illegal
  typedef enum logic [opcodeWidth-1:0] {
    opMov = 4'd0,
    opAdd = 4'd1,
    opSub = 4'd2,
    opAnd = 4'd3,
    opOr  = 4'd4,
    opShl = 4'd5,
    opShr = 4'd6,
    opLdi = 4'd7
  } opcodeT;

endpackage

`default_nettype wire

// ==== dataPathPkg.sv ====
// Data path types
`default_nettype none

package dataPathPkg;

  // Data word and shift amount sizes
  localparam int wordWidth = 16;
  localparam int shamtWidth = 4;

  typedef logic [wordWidth-1:0] wordT;
  typedef logic [shamtWidth-1:0] shamtT;

  // Condition code, bit 2 carry, bit 1 negative, bit 0 zero
  typedef struct packed {
    logic carry;
    logic negative;
    logic zero;
  } ccrT;

  // Instruction after decode, held in stage 1
  typedef struct packed {
    isaPkg::opcodeT opcode;
    isaPkg::regIdxT rd;
    isaPkg::regIdxT rs;
    shamtT          shamt;
    // Already sign-extended
    wordT           imm;
    logic           illegal;
  } decodedInstrT;

  // Retired instruction, held in stage 2
  typedef struct packed {
    isaPkg::regIdxT rd;
    wordT           value;
    ccrT            ccr;
    // Low when nothing was written back
    logic           wrote;
  } execResultT;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
// Instruction decoder
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
  input  isaPkg::instrWordT         instr,
  output dataPathPkg::decodedInstrT decoded
);

  import isaPkg::*;
  import dataPathPkg::*;

  // Raw fields
  logic [opcodeHi-opcodeLo:0] opBits;
  logic [immHi-immLo:0] immBits;
  wordT immExt;
  logic isIllegal;

  assign opBits = instr[opcodeHi:opcodeLo];
  assign immBits = instr[immHi:immLo];

  // Sign extension of the nine-bit immediate
  assign immExt = {{(wordWidth - $bits(immBits)){immBits[$high(immBits)]}}, immBits};

  // Anything beyond LDI has no operation behind it
  assign isIllegal = (opBits > opLdi);

  always_comb begin
    decoded.opcode = opcodeT'(opBits);
    // rd doubles as second source operand
    decoded.rd = instr[rdHi:rdLo];
    decoded.rs = instr[rsHi:rsLo];
    decoded.shamt = instr[shamtHi:shamtLo];
    decoded.imm = immExt;
    decoded.illegal = isIllegal;
  end

endmodule

`default_nettype wire

// ==== regFile.sv ====
// Register file, two read ports and one write port
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  logic               clk,
  input  logic               rstN,
  input  isaPkg::regIdxT     rdIdxA,
  input  isaPkg::regIdxT     rdIdxB,
  output dataPathPkg::wordT  rdDataA,
  output dataPathPkg::wordT  rdDataB,
  input  logic               wrEn,
  input  isaPkg::regIdxT     wrIdx,
  input  dataPathPkg::wordT  wrData
);

  import isaPkg::*;
  import dataPathPkg::*;

  // Architectural registers
  wordT regs [numRegs];

  // All registers start at zero
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  // Port A carries rs
  assign rdDataA = regs[rdIdxA];

  // Port B carries rd as the second operand
  assign rdDataB = regs[rdIdxB];

endmodule

`default_nettype wire

// ==== aluCore.sv ====
// Operation unit with condition code update
`timescale 1ns/100ps
`default_nettype none

module aluCore (
  input  dataPathPkg::decodedInstrT instrIn,
  input  dataPathPkg::wordT         rsVal,
  input  dataPathPkg::wordT         rdVal,
  input  dataPathPkg::ccrT          prevCcr,
  output dataPathPkg::wordT         resultVal,
  output dataPathPkg::ccrT          nextCcr,
  output logic                      wrEn
);

  import isaPkg::*;
  import dataPathPkg::*;

  // Extended results, top bit is carry or borrow
  logic [wordWidth:0] sumExt;
  logic [wordWidth:0] diffExt;
  logic [wordWidth:0] shlExt;
  // Low bit catches the last bit shifted out
  logic signed [wordWidth:0] shrExt;

  logic carryBit;
  logic setsFlags;

  assign sumExt = {1'b0, rsVal} + {1'b0, rdVal};
  assign diffExt = {1'b0, rsVal} - {1'b0, rdVal};
  assign shlExt = {1'b0, rsVal} << instrIn.shamt;
  assign shrExt = $signed({rsVal, 1'b0}) >>> instrIn.shamt;

  // Opcode-selected result
  always_comb begin
    resultVal = '0;
    carryBit = 1'b0;
    setsFlags = 1'b1;
    case (instrIn.opcode)
      opMov: begin
        resultVal = rsVal;
        setsFlags = 1'b0;
      end
      opAdd: begin
        {carryBit, resultVal} = sumExt;
      end
      opSub: begin
        {carryBit, resultVal} = diffExt;
      end
      // Logic ops leave carry clear
      opAnd: begin
        resultVal = rsVal & rdVal;
      end
      opOr: begin
        resultVal = rsVal | rdVal;
      end
      opShl: begin
        {carryBit, resultVal} = shlExt;
      end
      opShr: begin
        {resultVal, carryBit} = shrExt;
      end
      opLdi: begin
        resultVal = instrIn.imm;
        setsFlags = 1'b0;
      end
      // Illegal codes give zero and keep flags
      default: begin
        setsFlags = 1'b0;
      end
    endcase
  end

  // Flags from the result, or the old flags passed through
  always_comb begin
    if (setsFlags) begin
      nextCcr.carry = carryBit;
      nextCcr.negative = resultVal[wordWidth-1];
      nextCcr.zero = (resultVal == '0);
    end else begin
      nextCcr = prevCcr;
    end
  end

  assign wrEn = !instrIn.illegal;

endmodule

`default_nettype wire

// ==== execPipe.sv ====
// Two-stage execute pipeline
`timescale 1ns/100ps
`default_nettype none

module execPipe (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      inValid,
  output logic                      inReady,
  input  dataPathPkg::decodedInstrT decodedIn,
  output dataPathPkg::decodedInstrT stageInstr,
  input  dataPathPkg::wordT         aluResult,
  input  dataPathPkg::ccrT          aluCcr,
  input  logic                      aluWrEn,
  output logic                      rfWrEn,
  output isaPkg::regIdxT            rfWrIdx,
  output dataPathPkg::wordT         rfWrData,
  output dataPathPkg::ccrT          ccr,
  output logic                      outValid,
  input  logic                      outReady,
  output dataPathPkg::execResultT   result
);

  import dataPathPkg::*;

  // Stage 1, decoded instruction
  logic s1Valid;
  decodedInstrT s1Instr;

  // Stage 2, retired result
  logic s2Valid;
  execResultT s2Result;

  // Condition code register
  ccrT ccrReg;

  logic s2Accept;
  logic s1Move;
  logic inFire;

  // Stage 2 free or draining this cycle
  assign s2Accept = !s2Valid || outReady;
  assign s1Move = s1Valid && s2Accept;
  assign inReady = !s1Valid || s1Move;
  assign inFire = inValid && inReady;

  // Valid bits and condition code
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
      ccrReg <= '0;
    end else begin
      if (inFire) begin
        s1Valid <= 1'b1;
      end else if (s1Move) begin
        s1Valid <= 1'b0;
      end
      if (s1Move) begin
        s2Valid <= 1'b1;
        // Flags update in program order
        ccrReg <= aluCcr;
      end else if (outReady) begin
        s2Valid <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (inFire) begin
      s1Instr <= decodedIn;
    end
    if (s1Move) begin
      s2Result.rd <= s1Instr.rd;
      s2Result.value <= aluResult;
      s2Result.ccr <= aluCcr;
      s2Result.wrote <= aluWrEn;
    end
  end

  // Write-back strobe only on the move edge
  assign rfWrEn = s1Move && aluWrEn;
  assign rfWrIdx = s1Instr.rd;
  assign rfWrData = aluResult;

  assign stageInstr = s1Instr;
  assign ccr = ccrReg;
  assign outValid = s2Valid;
  assign result = s2Result;

endmodule

`default_nettype wire

// ==== aluSubsystem.sv ====
// Execute subsystem top
`timescale 1ns/100ps
`default_nettype none

module aluSubsystem (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    inValid,
  output logic                    inReady,
  input  isaPkg::instrWordT       instr,
  output logic                    outValid,
  input  logic                    outReady,
  output dataPathPkg::execResultT result,
  output dataPathPkg::ccrT        ccr
);

  import isaPkg::*;
  import dataPathPkg::*;

  // Decoder to stage 1
  decodedInstrT decoded;
  // Stage 1 to register file and operation unit
  decodedInstrT stageInstr;

  // Operand reads
  wordT rdDataA;
  wordT rdDataB;

  // Operation unit outputs
  wordT aluResult;
  ccrT aluCcr;
  logic aluWrEn;

  // Write-back
  logic rfWrEn;
  regIdxT rfWrIdx;
  wordT rfWrData;

  instrDecoder uDecoder (
    .instr   (instr),
    .decoded (decoded)
  );

  // rs on port A, rd on port B
  regFile uRegFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdIdxA  (stageInstr.rs),
    .rdIdxB  (stageInstr.rd),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (rfWrEn),
    .wrIdx   (rfWrIdx),
    .wrData  (rfWrData)
  );

  aluCore uAlu (
    .instrIn   (stageInstr),
    .rsVal     (rdDataA),
    .rdVal     (rdDataB),
    .prevCcr   (ccr),
    .resultVal (aluResult),
    .nextCcr   (aluCcr),
    .wrEn      (aluWrEn)
  );

  execPipe uPipe (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .inReady    (inReady),
    .decodedIn  (decoded),
    .stageInstr (stageInstr),
    .aluResult  (aluResult),
    .aluCcr     (aluCcr),
    .aluWrEn    (aluWrEn),
    .rfWrEn     (rfWrEn),
    .rfWrIdx    (rfWrIdx),
    .rfWrData   (rfWrData),
    .ccr        (ccr),
    .outValid   (outValid),
    .outReady   (outReady),
    .result     (result)
  );

endmodule

`default_nettype wire

// ==== aluRefModel.svh ====
// Execute reference model
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Instruction word from opcode and register fields
function automatic instrWordT encodeOp(input logic [3:0] op, input regIdxT rd,
                                       input regIdxT rs, input shamtT sh);
  instrWordT w;
  w = '0;
  w[opcodeHi:opcodeLo] = op;
  w[rdHi:rdLo] = rd;
  w[rsHi:rsLo] = rs;
  w[shamtHi:shamtLo] = sh;
  return w;
endfunction

// LDI word, immediate in the low nine bits
function automatic instrWordT encodeLdi(input regIdxT rd, input logic [8:0] imm);
  instrWordT w;
  w = '0;
  w[opcodeHi:opcodeLo] = 4'(opLdi);
  w[rdHi:rdLo] = rd;
  w[immHi:immLo] = imm;
  return w;
endfunction

// Expected retirement record for one instruction
function automatic execResultT refExecute(input instrWordT w, input wordT rsV,
                                          input wordT rdV, input ccrT prevCcr);
  logic [3:0] op;
  shamtT sh;
  wordT v;
  logic c;
  int sum;
  execResultT r;
  op = w[opcodeHi:opcodeLo];
  sh = w[shamtHi:shamtLo];
  v = '0;
  c = 1'b0;
  case (op)
    opMov: v = rsV;
    opAdd: begin
      sum = int'(rsV) + int'(rdV);
      v = wordT'(sum);
      c = (sum > 65535);
    end
    // Borrow when the subtrahend is larger
    opSub: begin
      v = rsV - rdV;
      c = (rdV > rsV);
    end
    opAnd: v = rsV & rdV;
    opOr: v = rsV | rdV;
    // One bit at a time, carry keeps the last bit out
    opShl: begin
      v = rsV;
      for (int i = 0; i < int'(sh); i++) begin
        c = v[15];
        v = {v[14:0], 1'b0};
      end
    end
    opShr: begin
      v = rsV;
      for (int i = 0; i < int'(sh); i++) begin
        c = v[0];
        v = {v[15], v[15:1]};
      end
    end
    opLdi: v = {{7{w[8]}}, w[8:0]};
    default: v = '0;
  endcase
  r.rd = w[rdHi:rdLo];
  r.value = v;
  r.wrote = (op <= 4'(opLdi));
  // Only ADD through SHR touch the flags
  if (op >= 4'(opAdd) && op <= 4'(opShr)) begin
    r.ccr.carry = c;
    r.ccr.negative = v[15];
    r.ccr.zero = (v == '0);
  end else begin
    r.ccr = prevCcr;
  end
  return r;
endfunction

`endif

// ==== aluSubsystemTb.sv ====
// Execute subsystem testbench
`timescale 1ns/100ps
`default_nettype none

module aluSubsystemTb;

  import isaPkg::*;
  import dataPathPkg::*;

  `include "aluRefModel.svh"

  localparam int clkPeriod = 40;
  localparam int waitLimit = 200;

  logic clk;
  logic rstN;
  logic inValid;
  logic inReady;
  instrWordT instr;
  logic outValid;
  logic outReady;
  execResultT result;
  ccrT ccr;

  // Sink mode with 0 always ready, 1 random gaps and 2 held low
  int readyMode;
  logic checkLatency;

  // Shadow state and expected results in acceptance order
  wordT shadowRegs [numRegs];
  ccrT shadowCcr;
  execResultT expQ [$];
  int cycleQ [$];
  int cycleCnt;
  execResultT expHead;
  logic headValid;
  int headCycle;
  int inFlight;

  aluSubsystem dut (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inReady  (inReady),
    .instr    (instr),
    .outValid (outValid),
    .outReady (outReady),
    .result   (result),
    .ccr      (ccr)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic reportFail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic timeoutFail(input string what);
    $display("Timeout: the wait for %s expired", what);
    $display("Simulation failed");
    $fatal(1, "wait timeout");
  endtask

  // Offer one word and hold it until accepted
  task automatic sendInstr(input instrWordT w);
    int waited;
    @(negedge clk);
    inValid = 1'b1;
    instr = w;
    waited = 0;
    @(posedge clk);
    while (!inReady && waited < waitLimit) begin
      @(posedge clk);
      waited++;
    end
    if (!inReady) timeoutFail("inReady on the instruction stream");
  endtask

  task automatic releaseInput();
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic waitDrain(input string what);
    int waited;
    waited = 0;
    @(posedge clk);
    while (inFlight != 0 && waited < waitLimit) begin
      @(posedge clk);
      waited++;
    end
    if (inFlight != 0) timeoutFail(what);
  endtask

  // Result stream sink
  initial begin
    forever begin
      @(negedge clk);
      if (readyMode == 1) outReady = ($urandom % 3) != 0;
      else outReady = (readyMode == 0);
    end
  end

  // Scoreboard bookkeeping with head values registered for the assertions
  always @(posedge clk) begin
    execResultT exp;
    if (!rstN) begin
      headValid <= 1'b0;
      expHead <= '0;
      headCycle <= 0;
      inFlight <= 0;
      cycleCnt <= 0;
    end else begin
      if (outValid && outReady && expQ.size() != 0) begin
        void'(expQ.pop_front());
        void'(cycleQ.pop_front());
      end
      if (inValid && inReady) begin
        exp = refExecute(instr, shadowRegs[instr[rsHi:rsLo]], shadowRegs[instr[rdHi:rdLo]],
                         shadowCcr);
        if (exp.wrote) shadowRegs[exp.rd] = exp.value;
        shadowCcr = exp.ccr;
        expQ.push_back(exp);
        cycleQ.push_back(cycleCnt);
      end
      headValid <= (expQ.size() != 0);
      expHead <= (expQ.size() != 0) ? expQ[0] : '0;
      headCycle <= (cycleQ.size() != 0) ? cycleQ[0] : 0;
      inFlight <= expQ.size();
      cycleCnt <= cycleCnt + 1;
    end
  end

  resultCheck: assert property (@(posedge clk) disable iff (!rstN)
    (outValid && outReady) |-> (headValid && result == expHead && ccr == expHead.ccr))
    else reportFail("retired result or ccr differs from the reference");

  latencyCheck: assert property (@(posedge clk) disable iff (!rstN)
    (outValid && outReady && checkLatency) |-> (cycleCnt - headCycle == 2))
    else reportFail("result latency is not two rising edges");

  backPressureCheck: assert property (@(posedge clk) disable iff (!rstN)
    (inFlight == 2 && !outReady) |-> !inReady)
    else reportFail("inReady high while both stages are full");

  occupancyCheck: assert property (@(posedge clk) disable iff (!rstN) inFlight <= 2)
    else reportFail("more than two instructions in flight");

  initial begin
    instrWordT w;
    logic [3:0] op;
    regIdxT idx;
    void'($urandom(31));
    rstN = 1'b0;
    inValid = 1'b0;
    instr = '0;
    outReady = 1'b1;
    readyMode = 0;
    checkLatency = 1'b0;
    shadowCcr = '0;
    for (int i = 0; i < numRegs; i++) shadowRegs[i] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    assert (!outValid && inReady && ccr == '0) else reportFail("state after reset is wrong");

    // Load then copy with flags left clear
    sendInstr(encodeLdi(3'd1, 9'h0A5));
    sendInstr(encodeOp(opMov, 3'd2, 3'd1, '0));
    for (int i = 0; i < numRegs; i++) sendInstr(encodeLdi(regIdxT'(i), 9'($urandom)));
    releaseInput();
    waitDrain("the reset and load sequence to drain");
    assert (ccr == '0) else reportFail("ccr changed by MOV or LDI");

    // Arithmetic with overflow and equal operands
    sendInstr(encodeLdi(3'd1, 9'h100));
    sendInstr(encodeOp(opAdd, 3'd1, 3'd1, '0));
    sendInstr(encodeOp(opSub, 3'd3, 3'd3, '0));
    sendInstr(encodeOp(opSub, 3'd2, 3'd1, '0));
    for (int i = 0; i < 40; i++) begin
      op = ($urandom % 2 != 0) ? opAdd : opSub;
      sendInstr(encodeOp(op, regIdxT'($urandom), regIdxT'($urandom), '0));
    end

    // Shifts of negative and positive words and then logic ops
    sendInstr(encodeLdi(3'd4, 9'h155));
    sendInstr(encodeLdi(3'd7, 9'h0B3));
    for (int sh = 0; sh < 16; sh++) begin
      sendInstr(encodeOp(opShl, 3'd5, 3'd4, shamtT'(sh)));
      sendInstr(encodeOp(opShr, 3'd6, 3'd4, shamtT'(sh)));
      sendInstr(encodeOp(opShr, 3'd5, 3'd7, shamtT'(sh)));
    end
    for (int i = 0; i < 16; i++) begin
      op = ($urandom % 2 != 0) ? opAnd : opOr;
      sendInstr(encodeOp(op, regIdxT'($urandom), regIdxT'($urandom), '0));
    end
    releaseInput();
    waitDrain("the arithmetic and shift results to drain");

    // Dependent chain at full rate
    @(negedge clk);
    checkLatency = 1'b1;
    sendInstr(encodeLdi(3'd1, 9'h003));
    for (int i = 0; i < 8; i++) sendInstr(encodeOp(opAdd, 3'd1, 3'd1, '0));
    sendInstr(encodeOp(opMov, 3'd0, 3'd1, '0));
    sendInstr(encodeOp(opSub, 3'd0, 3'd1, '0));
    releaseInput();
    waitDrain("the dependent chain to drain");
    @(negedge clk);
    checkLatency = 1'b0;

    // Random back-pressure
    readyMode = 1;
    for (int i = 0; i < 60; i++) begin
      w = instrWordT'($urandom);
      w[opcodeHi] = 1'b0;
      sendInstr(w);
    end
    releaseInput();
    readyMode = 0;
    waitDrain("the back-pressure results to drain");

    // Both stages full
    readyMode = 2;
    repeat (2) @(negedge clk);
    sendInstr(encodeOp(opAdd, 3'd2, 3'd3, '0));
    sendInstr(encodeOp(opOr, 3'd4, 3'd5, '0));
    releaseInput();
    assert (!inReady && outValid) else reportFail("pipeline did not stall when full");
    readyMode = 0;
    waitDrain("the stalled pipeline to drain");

    // Illegal opcodes each followed by a MOV of the untouched register
    for (int i = 0; i < 6; i++) begin
      w = instrWordT'($urandom);
      w[opcodeHi] = 1'b1;
      idx = w[rdHi:rdLo];
      sendInstr(w);
      sendInstr(encodeOp(opMov, regIdxT'(i), idx, '0));
    end
    releaseInput();
    waitDrain("the illegal opcode results to drain");
    assert (ccr == shadowCcr) else reportFail("ccr differs after illegal opcodes");

    // Pipeline empty once the last result has gone
    @(negedge clk);
    if (!outValid && inReady && expQ.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      reportFail("pipeline not idle after the last result");
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
isaPkg.sv
dataPathPkg.sv
instrDecoder.sv
regFile.sv
aluCore.sv
execPipe.sv
aluSubsystem.sv
aluSubsystemTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= aluSubsystemTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation passed

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) aluRefModel.svh $(FLIST)
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
